/* src/seq_pkg.sv */
package seq_pkg;

    // **********************************************************************
    // Word and quad geometry
    // **********************************************************************

    // One sequence word as seen on the input stream
    localparam int seq_width = 64;

    // Words packed into one quad
    localparam int lanes = 4;

    localparam int quad_width = seq_width * lanes;

    // Lane pointer inside the collector
    localparam int lane_idx_width = 2;

    // Live-lane count runs from 0 to lanes
    localparam int lane_count_width = 3;

    // **********************************************************************
    // Framing
    // **********************************************************************

    // Job tag that wraps around
    localparam int job_id_width = 8;

    // A word with this valid flag clear is a bubble
    localparam int seq_valid_bit = 0;

endpackage

/* src/seq_filter.sv */
`timescale 1ns/10ps

module seq_filter (
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          in_valid,
    input  logic                          in_end_of_job,
    input  logic [seq_pkg::seq_width-1:0] in_seq,
    output logic                          in_ready,

    output logic                          out_valid,
    output logic                          out_end_of_job,
    output logic [seq_pkg::seq_width-1:0] out_seq,
    input  logic                          out_ready
);

    logic                          full_reg;
    logic                          eoj_reg;
    logic [seq_pkg::seq_width-1:0] seq_reg;

    logic                          accept;
    logic                          keep;
    logic                          load;
    logic                          leave;

    // **********************************************************************
    // Handshake
    // **********************************************************************

    // Room when empty or when the held word goes out this cycle
    assign in_ready = !full_reg || out_ready;
    assign accept   = in_valid && in_ready;

    // Live words pass; a bubble survives only as an end-of-job terminator
    assign keep  = in_seq[seq_pkg::seq_valid_bit] || in_end_of_job;
    assign load  = accept && keep;
    assign leave = full_reg && out_ready;

    // **********************************************************************
    // One-entry register
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full_reg <= 1'b0;
            eoj_reg  <= 1'b0;
        end else if (load) begin
            full_reg <= 1'b1;
            eoj_reg  <= in_end_of_job;
        end else if (leave) begin
            full_reg <= 1'b0;
            eoj_reg  <= 1'b0;
        end
    end

    // Payload follows full_reg
    always_ff @(posedge clk) begin
        if (load) begin
            seq_reg <= in_seq;
        end
    end

    // Dropped bubbles take the accept cycle and leave nothing behind
    assign out_valid      = full_reg;
    assign out_end_of_job = eoj_reg;
    assign out_seq        = seq_reg;

endmodule

/* src/job_concat.sv */
`timescale 1ns/10ps

module job_concat (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           input_valid,
    input  logic                           input_end_of_job,
    input  logic [seq_pkg::seq_width-1:0]  input_seq,
    output logic                           input_ready,

    output logic                           output_valid,
    output logic                           output_end_of_job,
    output logic [seq_pkg::quad_width-1:0] output_seq_quad,
    input  logic                           output_ready
);

    // Collecting words when low and holding a finished quad when high
    logic                                holding_reg;
    logic [seq_pkg::lane_idx_width-1:0]  lane_idx_reg;
    logic [seq_pkg::quad_width-1:0]      quad_reg;
    logic                                eoj_reg;

    logic                                accept;
    logic                                last_lane;
    logic                                close_quad;

    // **********************************************************************
    // Handshake
    // **********************************************************************

    assign input_ready  = !holding_reg;
    assign output_valid = holding_reg;

    assign accept    = input_valid && !holding_reg;
    assign last_lane = lane_idx_reg == seq_pkg::lane_idx_width'(seq_pkg::lanes - 1);

    // Flush after the fourth word or early at end of job
    assign close_quad = last_lane || input_end_of_job;

    // **********************************************************************
    // Collector
    // **********************************************************************

    // Unwritten lanes must read as zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            holding_reg  <= 1'b0;
            lane_idx_reg <= '0;
            quad_reg     <= '0;
            eoj_reg      <= 1'b0;
        end else if (holding_reg) begin
            if (output_ready) begin
                // Quad taken so collecting resumes next cycle
                holding_reg  <= 1'b0;
                lane_idx_reg <= '0;
                quad_reg     <= '0;
                eoj_reg      <= 1'b0;
            end
        end else if (accept) begin
            quad_reg[lane_idx_reg * seq_pkg::seq_width +: seq_pkg::seq_width] <= input_seq;
            lane_idx_reg <= lane_idx_reg + 1'b1;
            eoj_reg      <= input_end_of_job;
            if (close_quad) begin
                holding_reg <= 1'b1;
            end
        end
    end

    assign output_seq_quad   = quad_reg;
    assign output_end_of_job = eoj_reg;

endmodule

/* src/quad_framer.sv */
`timescale 1ns/10ps

module quad_framer (
    input  logic                                 clk,
    input  logic                                 rst_n,

    input  logic                                 in_valid,
    input  logic                                 in_end_of_job,
    input  logic [seq_pkg::quad_width-1:0]       in_quad,
    output logic                                 in_ready,

    output logic                                 out_valid,
    output logic                                 out_end_of_job,
    output logic [seq_pkg::quad_width-1:0]       out_quad,
    output logic [seq_pkg::lane_count_width-1:0] out_lane_count,
    output logic [seq_pkg::job_id_width-1:0]     out_job_id,
    input  logic                                 out_ready
);

    logic                                 valid_reg;
    logic                                 eoj_reg;
    logic [seq_pkg::quad_width-1:0]       quad_reg;
    logic [seq_pkg::lane_count_width-1:0] lane_count_reg;
    logic [seq_pkg::job_id_width-1:0]     job_id_reg;
    logic [seq_pkg::job_id_width-1:0]     job_cnt_reg;

    logic                                 accept;
    logic                                 out_fire;
    logic [seq_pkg::lane_count_width-1:0] lane_count;
    logic [seq_pkg::job_id_width-1:0]     job_next;

    assign in_ready = !valid_reg || out_ready;
    assign accept   = in_valid && in_ready;
    assign out_fire = valid_reg && out_ready;

    // **********************************************************************
    // Live-lane count and job number
    // **********************************************************************

    always_comb begin
        lane_count = '0;
        for (int i = 0; i < seq_pkg::lanes; i++) begin
            lane_count = lane_count + seq_pkg::lane_count_width'(
                in_quad[i * seq_pkg::seq_width + seq_pkg::seq_valid_bit]);
        end
    end

    // The job closes once its last quad is taken downstream
    // A quad captured in that same cycle already carries the new number
    assign job_next = job_cnt_reg + seq_pkg::job_id_width'(out_fire && eoj_reg);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            job_cnt_reg <= '0;
        end else begin
            job_cnt_reg <= job_next;
        end
    end

    // **********************************************************************
    // Output register
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_reg <= 1'b0;
            eoj_reg   <= 1'b0;
        end else if (accept) begin
            valid_reg <= 1'b1;
            eoj_reg   <= in_end_of_job;
        end else if (out_fire) begin
            valid_reg <= 1'b0;
            eoj_reg   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            quad_reg       <= in_quad;
            lane_count_reg <= lane_count;
            job_id_reg     <= job_next;
        end
    end

    assign out_valid      = valid_reg;
    assign out_end_of_job = eoj_reg;
    assign out_quad       = quad_reg;
    assign out_lane_count = lane_count_reg;
    assign out_job_id     = job_id_reg;

endmodule

/* src/seq_quad_pipe.sv */
`timescale 1ns/10ps

module seq_quad_pipe (
    input  logic                                 clk,
    input  logic                                 rst_n,

    input  logic                                 in_valid,
    input  logic                                 in_end_of_job,
    input  logic [seq_pkg::seq_width-1:0]        in_seq,
    output logic                                 in_ready,

    output logic                                 out_valid,
    output logic                                 out_end_of_job,
    output logic [seq_pkg::quad_width-1:0]       out_quad,
    output logic [seq_pkg::lane_count_width-1:0] out_lane_count,
    output logic [seq_pkg::job_id_width-1:0]     out_job_id,
    input  logic                                 out_ready
);

    // Filter to collector
    logic                           filt_valid;
    logic                           filt_end_of_job;
    logic [seq_pkg::seq_width-1:0]  filt_seq;
    logic                           filt_ready;

    // Collector to framer
    logic                           cat_valid;
    logic                           cat_end_of_job;
    logic [seq_pkg::quad_width-1:0] cat_quad;
    logic                           cat_ready;

    seq_filter seq_filter_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_end_of_job  (in_end_of_job),
        .in_seq         (in_seq),
        .in_ready       (in_ready),
        .out_valid      (filt_valid),
        .out_end_of_job (filt_end_of_job),
        .out_seq        (filt_seq),
        .out_ready      (filt_ready)
    );

    job_concat job_concat_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .input_valid       (filt_valid),
        .input_end_of_job  (filt_end_of_job),
        .input_seq         (filt_seq),
        .input_ready       (filt_ready),
        .output_valid      (cat_valid),
        .output_end_of_job (cat_end_of_job),
        .output_seq_quad   (cat_quad),
        .output_ready      (cat_ready)
    );

    quad_framer quad_framer_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (cat_valid),
        .in_end_of_job  (cat_end_of_job),
        .in_quad        (cat_quad),
        .in_ready       (cat_ready),
        .out_valid      (out_valid),
        .out_end_of_job (out_end_of_job),
        .out_quad       (out_quad),
        .out_lane_count (out_lane_count),
        .out_job_id     (out_job_id),
        .out_ready      (out_ready)
    );

endmodule

/* testbench/tb_seq_quad_tasks.svh */
// **********************************************************************
// Reference model and expected quads
// **********************************************************************

logic [seq_pkg::quad_width-1:0]       exp_quad[$];
logic                                 exp_eoj[$];
logic [seq_pkg::lane_count_width-1:0] exp_lane_count[$];
logic [seq_pkg::job_id_width-1:0]     exp_job_id[$];

logic [seq_pkg::quad_width-1:0]       model_quad = '0;
int                                   model_lane = 0;
int                                   model_job = 0;

// Words queued for the driver
logic [seq_pkg::seq_width-1:0]        stim_seq[$];
logic                                 stim_eoj[$];
logic                                 rx_done;

function automatic logic [seq_pkg::seq_width-1:0] make_word(input int tag, input int idx,
                                                            input logic live);
    return {16'(tag), 32'(idx), 15'h0, live};
endfunction

// Queue one input word and run it through the filter, concat and framer rules
task automatic add_word(input logic [seq_pkg::seq_width-1:0] word, input logic eoj);
    int live;
    stim_seq.push_back(word);
    stim_eoj.push_back(eoj);
    if (word[seq_pkg::seq_valid_bit] || eoj) begin
        model_quad[model_lane * seq_pkg::seq_width +: seq_pkg::seq_width] = word;
        model_lane++;
        if (model_lane == seq_pkg::lanes || eoj) begin
            live = 0;
            for (int i = 0; i < seq_pkg::lanes; i++) begin
                live += model_quad[i * seq_pkg::seq_width + seq_pkg::seq_valid_bit];
            end
            exp_quad.push_back(model_quad);
            exp_eoj.push_back(eoj);
            exp_lane_count.push_back(seq_pkg::lane_count_width'(live));
            exp_job_id.push_back(seq_pkg::job_id_width'(model_job));
            if (eoj) begin
                model_job++;
            end
            model_quad = '0;
            model_lane = 0;
        end
    end
endtask

// **********************************************************************
// Driver and monitor
// **********************************************************************

task automatic send_words();
    for (int i = 0; i < stim_seq.size(); i++) begin
        @(negedge clk);
        in_valid      = 1'b1;
        in_seq        = stim_seq[i];
        in_end_of_job = stim_eoj[i];
        @(posedge clk);
        while (!in_ready) @(posedge clk);
    end
    @(negedge clk);
    in_valid      = 1'b0;
    in_end_of_job = 1'b0;
    in_seq        = '0;
    stim_seq.delete();
    stim_eoj.delete();
endtask

task automatic receive_quads(input int count);
    logic [seq_pkg::quad_width-1:0]       quad;
    logic                                 eoj;
    logic [seq_pkg::lane_count_width-1:0] lane_count;
    logic [seq_pkg::job_id_width-1:0]     job_id;
    repeat (count) begin
        @(posedge clk);
        while (!(out_valid && out_ready)) @(posedge clk);
        quad       = exp_quad.pop_front();
        eoj        = exp_eoj.pop_front();
        lane_count = exp_lane_count.pop_front();
        job_id     = exp_job_id.pop_front();
        assert (out_quad === quad) else begin
            $display("Error %s: quad expected %h actual %h", test_name, quad, out_quad);
            error_count++;
        end
        assert (out_end_of_job === eoj) else begin
            $display("Error %s: end_of_job expected %b actual %b", test_name, eoj,
                     out_end_of_job);
            error_count++;
        end
        assert (out_lane_count === lane_count) else begin
            $display("Error %s: lane_count expected %0d actual %0d", test_name, lane_count,
                     out_lane_count);
            error_count++;
        end
        assert (out_job_id === job_id) else begin
            $display("Error %s: job_id expected %0d actual %0d", test_name, job_id, out_job_id);
            error_count++;
        end
    end
    rx_done = 1'b1;
endtask

task automatic drive_random_ready();
    while (!rx_done) begin
        @(negedge clk);
        rand_val  = $random(seed);
        out_ready = rand_val[0];
    end
endtask

// Nothing more may come out once the expected quads are in
task automatic check_idle();
    repeat (8) begin
        @(posedge clk);
        assert (!out_valid) else begin
            $display("%s: an extra quad appeared after all expected quads", test_name);
            error_count++;
        end
    end
endtask

task automatic run_traffic(input logic toggle_ready);
    int count;
    count   = exp_quad.size();
    rx_done = 1'b0;
    fork
        send_words();
        receive_quads(count);
        if (toggle_ready) drive_random_ready();
    join
    @(negedge clk);
    out_ready = 1'b1;
    check_idle();
endtask

/* testbench/tb_seq_quad_pipe.sv */
`timescale 1ns/10ps

module tb_seq_quad_pipe;

    // The tests take under 600 cycles
    localparam int max_cycles = 2000;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 in_valid;
    logic                                 in_end_of_job;
    logic [seq_pkg::seq_width-1:0]        in_seq;
    logic                                 in_ready;
    logic                                 out_valid;
    logic                                 out_end_of_job;
    logic [seq_pkg::quad_width-1:0]       out_quad;
    logic [seq_pkg::lane_count_width-1:0] out_lane_count;
    logic [seq_pkg::job_id_width-1:0]     out_job_id;
    logic                                 out_ready;

    int    error_count = 0;
    int    cycle_count = 0;
    int    seed;
    int    rand_val;
    string test_name;

    seq_quad_pipe seq_quad_pipe_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_end_of_job  (in_end_of_job),
        .in_seq         (in_seq),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_end_of_job (out_end_of_job),
        .out_quad       (out_quad),
        .out_lane_count (out_lane_count),
        .out_job_id     (out_job_id),
        .out_ready      (out_ready)
    );

    `include "tb_seq_quad_tasks.svh"

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Timeout after %0d cycles, the expected quads did not arrive", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // **********************************************************************
    // Directed tests
    // **********************************************************************

    task automatic check_reset_state();
        test_name = "reset_state";
        assert (out_valid === 1'b0) else begin
            $display("Error %s: out_valid expected 0 actual %b", test_name, out_valid);
            error_count++;
        end
        assert (in_ready === 1'b1) else begin
            $display("Error %s: in_ready expected 1 actual %b", test_name, in_ready);
            error_count++;
        end
    endtask

    task automatic full_job_test();
        test_name = "full_job";
        for (int i = 0; i < 8; i++) begin
            add_word(make_word(2, i, 1'b1), i == 7);
        end
        run_traffic(1'b0);
    endtask

    task automatic short_job_test();
        test_name = "short_job_bubbles";
        add_word(make_word(3, 0, 1'b0), 1'b0);
        add_word(make_word(3, 1, 1'b1), 1'b0);
        add_word(make_word(3, 2, 1'b0), 1'b0);
        add_word(make_word(3, 3, 1'b0), 1'b0);
        add_word(make_word(3, 4, 1'b1), 1'b0);
        add_word(make_word(3, 5, 1'b0), 1'b0);
        add_word(make_word(3, 6, 1'b1), 1'b1);
        run_traffic(1'b0);
    endtask

    task automatic terminator_test();
        test_name = "terminator_bubble";
        add_word(make_word(4, 0, 1'b1), 1'b0);
        add_word(make_word(4, 1, 1'b1), 1'b0);
        add_word(make_word(4, 2, 1'b0), 1'b1);
        run_traffic(1'b0);
    endtask

    task automatic backpressure_test();
        int job_len[4] = '{5, 4, 1, 7};
        int idx;
        test_name = "back_pressure";
        idx = 0;
        for (int j = 0; j < 4; j++) begin
            for (int w = 0; w < job_len[j]; w++) begin
                rand_val = $random(seed);
                // Random bubble ahead of some live words
                if (rand_val[1]) begin
                    add_word(make_word(5 + j, idx, 1'b0), 1'b0);
                    idx++;
                end
                add_word(make_word(5 + j, idx, 1'b1), w == job_len[j] - 1);
                idx++;
            end
        end
        run_traffic(1'b1);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_end_of_job = 1'b0;
        in_seq        = '0;
        out_ready     = 1'b1;
        seed          = 49016;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_reset_state();
        full_job_test();
        short_job_test();
        terminator_test();
        backpressure_test();

        $display("Errors: %0d, cycles: %0d", error_count, cycle_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+testbench
src/seq_pkg.sv
src/seq_filter.sv
src/job_concat.sv
src/quad_framer.sv
src/seq_quad_pipe.sv
testbench/tb_seq_quad_pipe.sv

/* Bender.yml */
package:
  name: seq_quad_pipe

sources:
  - src/seq_pkg.sv
  - src/seq_filter.sv
  - src/job_concat.sv
  - src/quad_framer.sv
  - src/seq_quad_pipe.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_seq_quad_pipe.sv
